/* verilog.f */
+incdir+sim
common/eth_mux_pkg.sv
logic/arbiter.sv
logic/axis_skid_buffer.sv
eth_arb_mux/eth_arb_mux.sv
sim/tb_eth_arb_mux.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_eth_arb_mux -f verilog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Verification passed$" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

/* sim/tb_eth_arb_mux_tasks.svh */
// source driver, output collector, LCG, value check, frame checks and directed tests

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// header fields carry the tag so a frame can be identified at the output
function automatic mac_addr_t dest_of(input int tag);
    return {40'h02_00_00_00_00, 8'(tag)};
endfunction

function automatic mac_addr_t srcmac_of(input int tag);
    return {32'h0a_00_00_00, 8'(frame_src[tag]), 8'(tag)};
endfunction

function automatic eth_type_t type_of(input int tag);
    return 16'h8800 + 16'(tag);
endfunction

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        error_count++;
        $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
endtask

task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
endtask

task automatic apply_reset();
    rst                  = 1'b1;
    s_eth_hdr_valid      = '0;
    s_eth_payload_tvalid = '0;
    m_eth_hdr_ready      = 1'b1;
    m_eth_payload_tready = 1'b1;
    next_cycle();
    next_cycle();
    rst = 1'b0;
    hdr_tags.delete();
    pay_data.delete();
    pay_last.delete();
    pay_user.delete();
    exp_src.delete();
    frames_done = 0;
endtask

function automatic void setup_frame(input int tag, input int src, input int len);
    logic [31:0] r;
    frame_src[tag] = src;
    frame_len[tag] = len;
    r = lcg_next();
    frame_user[tag] = r[24];
    for (int j = 0; j < len; j++) begin
        r = lcg_next();
        frame_mem[tag][j] = r[23:16];
    end
endfunction

// header first, then the payload beats
task automatic send_frame(input int src, input int tag);
    s_eth_dest_mac[src]  = dest_of(tag);
    s_eth_src_mac[src]   = srcmac_of(tag);
    s_eth_type[src]      = type_of(tag);
    s_eth_hdr_valid[src] = 1'b1;
    while (!s_eth_hdr_ready[src]) next_cycle();
    next_cycle();
    s_eth_hdr_valid[src] = 1'b0;
    for (int j = 0; j < frame_len[tag]; j++) begin
        s_eth_payload_tdata[src]  = frame_mem[tag][j];
        s_eth_payload_tlast[src]  = (j == frame_len[tag] - 1);
        s_eth_payload_tuser[src]  = frame_user[tag];
        s_eth_payload_tvalid[src] = 1'b1;
        while (!s_eth_payload_tready[src]) next_cycle();
        next_cycle();
    end
    s_eth_payload_tvalid[src] = 1'b0;
    s_eth_payload_tlast[src]  = 1'b0;
endtask

task automatic send_two_frames(input int src);
    send_frame(src, src);
    send_frame(src, src + 4);
endtask

// sampled mid cycle, where valid and ready are both settled
task automatic collect_outputs();
    int tag;
    forever begin
        @(negedge clk);
        if (!rst && m_eth_hdr_valid && m_eth_hdr_ready) begin
            tag = int'(m_eth_dest_mac[3:0]);
            hdr_tags.push_back(tag);
            check_value("m_eth_dest_mac", m_eth_dest_mac, dest_of(tag));
            check_value("m_eth_src_mac", m_eth_src_mac, srcmac_of(tag));
            check_value("m_eth_type", m_eth_type, type_of(tag));
        end
        if (!rst && m_eth_payload_tvalid && m_eth_payload_tready) begin
            pay_data.push_back(m_eth_payload_tdata);
            pay_last.push_back(m_eth_payload_tlast);
            pay_user.push_back(m_eth_payload_tuser[0]);
            if (m_eth_payload_tlast) begin
                frames_done++;
            end
        end
    end
endtask

task automatic wait_frames(input int n);
    int cycles;
    cycles = 0;
    while (frames_done < n && cycles < 300) begin
        next_cycle();
        cycles++;
    end
    if (frames_done < n) begin
        error_count++;
        $display("only %0d of %0d frames left the mux in time", frames_done, n);
    end
    next_cycle();
endtask

// walks the headers in output order and matches each one to its payload
task automatic check_frames(input int n, input bit ordered);
    int tag;
    int k;
    k = 0;
    check_value("header count", hdr_tags.size(), n);
    for (int f = 0; f < hdr_tags.size(); f++) begin
        tag = hdr_tags[f];
        if (ordered && f < exp_src.size()) begin
            check_value("header source index", frame_src[tag], exp_src[f]);
        end
        for (int j = 0; j < frame_len[tag]; j++) begin
            if (k >= pay_data.size()) begin
                error_count++;
                $display("payload stream ended inside the frame with tag %0d", tag);
                return;
            end
            check_value("m_eth_payload_tdata", pay_data[k], frame_mem[tag][j]);
            check_value("m_eth_payload_tlast", pay_last[k], j == frame_len[tag] - 1);
            check_value("m_eth_payload_tuser", pay_user[k], frame_user[tag]);
            k++;
        end
    end
    check_value("payload beat count", pay_data.size(), k);
endtask

task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
        tests_failed++;
        $display("test %s: %0d errors", name, error_count - errs_before);
    end else begin
        $display("test %s: ok", name);
    end
endtask

task automatic test_single_frame();
    int errs;
    errs = error_count;
    apply_reset();
    check_value("m_eth_hdr_valid", m_eth_hdr_valid, 0);
    check_value("m_eth_payload_tvalid", m_eth_payload_tvalid, 0);
    check_value("s_eth_hdr_ready", s_eth_hdr_ready, 0);
    check_value("s_eth_payload_tready", s_eth_payload_tready, 0);
    check_value("grant_valid", eth_arb_mux_inst.grant_valid, 0);
    setup_frame(0, 2, 6);
    fork
        send_frame(2, 0);
        begin
            // header register loads on the second edge after hdr_valid
            next_cycle();
            check_value("m_eth_hdr_valid", m_eth_hdr_valid, 0);
            next_cycle();
            check_value("m_eth_hdr_valid", m_eth_hdr_valid, 1);
            check_value("m_eth_dest_mac", m_eth_dest_mac, dest_of(0));
            check_value("m_eth_src_mac", m_eth_src_mac, srcmac_of(0));
            check_value("m_eth_type", m_eth_type, type_of(0));
        end
    join
    wait_frames(1);
    check_frames(1, 0);
    report_test("single frame", errs);
endtask

task automatic test_fixed_priority();
    int errs;
    errs = error_count;
    apply_reset();
    arb_mode = ARB_PRIORITY;
    for (int t = 0; t < 5; t++) begin
        setup_frame(t, t % 4, 6);
    end
    exp_src = {0, 1, 2, 0, 3};
    fork
        begin
            send_frame(0, 0);
            // ask again once source 2 owns the output
            while (!s_eth_hdr_ready[2]) next_cycle();
            send_frame(0, 4);
        end
        send_frame(1, 1);
        send_frame(2, 2);
        send_frame(3, 3);
    join
    wait_frames(5);
    check_frames(5, 1);
    report_test("fixed priority", errs);
endtask

task automatic test_round_robin();
    int errs;
    errs = error_count;
    apply_reset();
    arb_mode = ARB_ROUND_ROBIN;
    for (int t = 0; t < 8; t++) begin
        setup_frame(t, t % 4, 3 + t % 3);
    end
    exp_src = {0, 1, 2, 3, 0, 1, 2, 3};
    fork
        send_two_frames(0);
        send_two_frames(1);
        send_two_frames(2);
        send_two_frames(3);
    join
    wait_frames(8);
    check_frames(8, 1);
    report_test("round robin", errs);
endtask

task automatic test_payload_backpressure();
    int          errs;
    logic [31:0] r;
    bit          done;
    errs = error_count;
    apply_reset();
    arb_mode = ARB_ROUND_ROBIN;
    for (int t = 0; t < 8; t++) begin
        r = lcg_next();
        setup_frame(t, t % 4, 1 + int'(r[19:16] % 4'd12));
    end
    done = 1'b0;
    fork
        begin
            fork
                send_two_frames(0);
                send_two_frames(1);
                send_two_frames(2);
                send_two_frames(3);
            join
            wait_frames(8);
            done = 1'b1;
        end
        begin
            // ready about three cycles in four
            while (!done) begin
                r = lcg_next();
                m_eth_payload_tready = (r[17:16] != 2'b00);
                next_cycle();
            end
        end
    join
    m_eth_payload_tready = 1'b1;
    check_frames(8, 0);
    report_test("payload back-pressure", errs);
endtask

task automatic test_header_backpressure();
    int errs;
    errs = error_count;
    apply_reset();
    arb_mode = ARB_PRIORITY;
    setup_frame(0, 0, 4);
    setup_frame(1, 1, 4);
    exp_src = {0, 1};
    m_eth_hdr_ready = 1'b0;
    fork
        send_frame(0, 0);
        send_frame(1, 1);
        begin
            while (!m_eth_hdr_valid) next_cycle();
            repeat (20) begin
                check_value("m_eth_hdr_valid", m_eth_hdr_valid, 1);
                check_value("m_eth_dest_mac", m_eth_dest_mac, dest_of(0));
                check_value("m_eth_src_mac", m_eth_src_mac, srcmac_of(0));
                check_value("m_eth_type", m_eth_type, type_of(0));
                check_value("s_eth_hdr_ready[1]", s_eth_hdr_ready[1], 0);
                next_cycle();
            end
            m_eth_hdr_ready = 1'b1;
        end
    join
    wait_frames(2);
    check_frames(2, 1);
    report_test("header back-pressure", errs);
endtask

/* sim/tb_eth_arb_mux.sv */
// testbench top with clock, reset, DUT instance, output collector, watchdog and test sequence
`timescale 1ns/1ps

module tb_eth_arb_mux import eth_mux_pkg::*; ();

    localparam int S_COUNT         = 4;
    localparam int DATA_WIDTH      = 8;
    localparam int USER_WIDTH      = 1;
    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    // about twice the length of all tests together
    localparam int WATCHDOG_CYCLES = 4000;

    logic      clk;
    logic      rst;
    arb_mode_e arb_mode;

    logic [S_COUNT-1:0]                 s_eth_hdr_valid;
    logic [S_COUNT-1:0]                 s_eth_hdr_ready;
    mac_addr_t [S_COUNT-1:0]            s_eth_dest_mac;
    mac_addr_t [S_COUNT-1:0]            s_eth_src_mac;
    eth_type_t [S_COUNT-1:0]            s_eth_type;
    logic [S_COUNT-1:0][DATA_WIDTH-1:0] s_eth_payload_tdata;
    logic [S_COUNT-1:0]                 s_eth_payload_tvalid;
    logic [S_COUNT-1:0]                 s_eth_payload_tready;
    logic [S_COUNT-1:0]                 s_eth_payload_tlast;
    logic [S_COUNT-1:0][USER_WIDTH-1:0] s_eth_payload_tuser;

    logic                  m_eth_hdr_valid;
    logic                  m_eth_hdr_ready;
    mac_addr_t             m_eth_dest_mac;
    mac_addr_t             m_eth_src_mac;
    eth_type_t             m_eth_type;
    logic [DATA_WIDTH-1:0] m_eth_payload_tdata;
    logic                  m_eth_payload_tvalid;
    logic                  m_eth_payload_tready;
    logic                  m_eth_payload_tlast;
    logic [USER_WIDTH-1:0] m_eth_payload_tuser;

    int          error_count;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lcg_state;

    // frame descriptors, indexed by tag
    int         frame_src [16];
    int         frame_len [16];
    logic       frame_user [16];
    logic [7:0] frame_mem [16][16];
    int         exp_src [$];

    // what left the mux, in order
    int         hdr_tags [$];
    logic [7:0] pay_data [$];
    logic       pay_last [$];
    logic       pay_user [$];
    int         frames_done;

    `include "tb_eth_arb_mux_tasks.svh"

    eth_arb_mux eth_arb_mux_inst (
        .clk                  (clk),
        .rst                  (rst),
        .arb_mode             (arb_mode),
        .s_eth_hdr_valid      (s_eth_hdr_valid),
        .s_eth_hdr_ready      (s_eth_hdr_ready),
        .s_eth_dest_mac       (s_eth_dest_mac),
        .s_eth_src_mac        (s_eth_src_mac),
        .s_eth_type           (s_eth_type),
        .s_eth_payload_tdata  (s_eth_payload_tdata),
        .s_eth_payload_tvalid (s_eth_payload_tvalid),
        .s_eth_payload_tready (s_eth_payload_tready),
        .s_eth_payload_tlast  (s_eth_payload_tlast),
        .s_eth_payload_tuser  (s_eth_payload_tuser),
        .m_eth_hdr_valid      (m_eth_hdr_valid),
        .m_eth_hdr_ready      (m_eth_hdr_ready),
        .m_eth_dest_mac       (m_eth_dest_mac),
        .m_eth_src_mac        (m_eth_src_mac),
        .m_eth_type           (m_eth_type),
        .m_eth_payload_tdata  (m_eth_payload_tdata),
        .m_eth_payload_tvalid (m_eth_payload_tvalid),
        .m_eth_payload_tready (m_eth_payload_tready),
        .m_eth_payload_tlast  (m_eth_payload_tlast),
        .m_eth_payload_tuser  (m_eth_payload_tuser)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        collect_outputs();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst                  = 1'b1;
        arb_mode             = ARB_PRIORITY;
        s_eth_hdr_valid      = '0;
        s_eth_dest_mac       = '0;
        s_eth_src_mac        = '0;
        s_eth_type           = '0;
        s_eth_payload_tdata  = '0;
        s_eth_payload_tvalid = '0;
        s_eth_payload_tlast  = '0;
        s_eth_payload_tuser  = '0;
        m_eth_hdr_ready      = 1'b1;
        m_eth_payload_tready = 1'b1;
        error_count          = 0;
        tests_run            = 0;
        tests_failed         = 0;
        frames_done          = 0;
        lcg_state            = 32'd35;

        test_single_frame();
        test_fixed_priority();
        test_round_robin();
        test_payload_backpressure();
        test_header_backpressure();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* eth_arb_mux/eth_arb_mux.sv */
// ethernet frame arbitrated mux, header register, frame tracking and payload routing
`timescale 1ns/1ps

module eth_arb_mux import eth_mux_pkg::*; #(
    parameter int S_COUNT               = 4,
    parameter int DATA_WIDTH            = 8,
    parameter int USER_WIDTH            = 1,
    // 1 gives the lowest index first
    parameter int ARB_LSB_HIGH_PRIORITY = 1,
    localparam int CL_S_COUNT           = (S_COUNT > 1) ? $clog2(S_COUNT) : 1
) (
    input  logic                                clk,
    input  logic                                rst,
    input  arb_mode_e                           arb_mode,

    // frame inputs, one slice per source
    input  logic [S_COUNT-1:0]                  s_eth_hdr_valid,
    output logic [S_COUNT-1:0]                  s_eth_hdr_ready,
    input  mac_addr_t [S_COUNT-1:0]             s_eth_dest_mac,
    input  mac_addr_t [S_COUNT-1:0]             s_eth_src_mac,
    input  eth_type_t [S_COUNT-1:0]             s_eth_type,
    input  logic [S_COUNT-1:0][DATA_WIDTH-1:0]  s_eth_payload_tdata,
    input  logic [S_COUNT-1:0]                  s_eth_payload_tvalid,
    output logic [S_COUNT-1:0]                  s_eth_payload_tready,
    input  logic [S_COUNT-1:0]                  s_eth_payload_tlast,
    input  logic [S_COUNT-1:0][USER_WIDTH-1:0]  s_eth_payload_tuser,

    // frame output
    output logic                                m_eth_hdr_valid,
    input  logic                                m_eth_hdr_ready,
    output mac_addr_t                           m_eth_dest_mac,
    output mac_addr_t                           m_eth_src_mac,
    output eth_type_t                           m_eth_type,
    output logic [DATA_WIDTH-1:0]               m_eth_payload_tdata,
    output logic                                m_eth_payload_tvalid,
    input  logic                                m_eth_payload_tready,
    output logic                                m_eth_payload_tlast,
    output logic [USER_WIDTH-1:0]               m_eth_payload_tuser
);

    frame_state_e frame_state;
    frame_state_e frame_state_next;

    logic [S_COUNT-1:0] hdr_ready_reg;
    logic [S_COUNT-1:0] hdr_ready_next;
    logic               hdr_valid_reg;
    logic               hdr_valid_next;
    logic               frame_start;
    mac_addr_t          dest_mac_reg;
    mac_addr_t          src_mac_reg;
    eth_type_t          type_reg;

    logic [S_COUNT-1:0]    request;
    logic [S_COUNT-1:0]    acknowledge;
    logic [S_COUNT-1:0]    grant;
    logic                  grant_valid;
    logic [CL_S_COUNT-1:0] grant_encoded;

    logic [DATA_WIDTH-1:0] cur_tdata;
    logic                  cur_tvalid;
    logic                  cur_tlast;
    logic [USER_WIDTH-1:0] cur_tuser;
    logic                  buf_in_tvalid;
    logic                  buf_in_ready;

    arbiter #(
        .S_COUNT               (S_COUNT),
        .ARB_LSB_HIGH_PRIORITY (ARB_LSB_HIGH_PRIORITY)
    ) arb_inst (
        .clk           (clk),
        .rst           (rst),
        .arb_mode      (arb_mode),
        .request       (request),
        .acknowledge   (acknowledge),
        .grant         (grant),
        .grant_valid   (grant_valid),
        .grant_encoded (grant_encoded)
    );

    // the granted source stops requesting until it is released
    assign request     = s_eth_hdr_valid & ~grant;
    assign acknowledge = grant & s_eth_payload_tvalid & s_eth_payload_tready &
                         s_eth_payload_tlast;

    // selected source payload
    assign cur_tdata  = s_eth_payload_tdata[grant_encoded];
    assign cur_tvalid = s_eth_payload_tvalid[grant_encoded];
    assign cur_tlast  = s_eth_payload_tlast[grant_encoded];
    assign cur_tuser  = s_eth_payload_tuser[grant_encoded];

    assign s_eth_payload_tready = S_COUNT'(buf_in_ready && grant_valid) << grant_encoded;
    assign buf_in_tvalid        = cur_tvalid && buf_in_ready && grant_valid;

    // start when idle with a grant and the header register free
    assign frame_start = (frame_state == FRAME_IDLE) && grant_valid &&
                         (m_eth_hdr_ready || !hdr_valid_reg);

    always_comb begin
        frame_state_next = frame_state;
        hdr_ready_next   = '0;
        hdr_valid_next   = hdr_valid_reg && !m_eth_hdr_ready;

        // end of frame on the last beat transfer
        if (|acknowledge) begin
            frame_state_next = FRAME_IDLE;
        end
        if (frame_start) begin
            frame_state_next = FRAME_ACTIVE;
            hdr_ready_next   = grant;
            hdr_valid_next   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_state   <= FRAME_IDLE;
            hdr_ready_reg <= '0;
            hdr_valid_reg <= 1'b0;
        end else begin
            frame_state   <= frame_state_next;
            hdr_ready_reg <= hdr_ready_next;
            hdr_valid_reg <= hdr_valid_next;
        end
    end

    // header capture from the granted source
    always_ff @(posedge clk) begin
        if (frame_start) begin
            dest_mac_reg <= s_eth_dest_mac[grant_encoded];
            src_mac_reg  <= s_eth_src_mac[grant_encoded];
            type_reg     <= s_eth_type[grant_encoded];
        end
    end

    assign s_eth_hdr_ready = hdr_ready_reg;
    assign m_eth_hdr_valid = hdr_valid_reg;
    assign m_eth_dest_mac  = dest_mac_reg;
    assign m_eth_src_mac   = src_mac_reg;
    assign m_eth_type      = type_reg;

    axis_skid_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) out_buf_inst (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (cur_tdata),
        .in_tvalid  (buf_in_tvalid),
        .in_tlast   (cur_tlast),
        .in_tuser   (cur_tuser),
        .in_ready   (buf_in_ready),
        .out_tdata  (m_eth_payload_tdata),
        .out_tvalid (m_eth_payload_tvalid),
        .out_tready (m_eth_payload_tready),
        .out_tlast  (m_eth_payload_tlast),
        .out_tuser  (m_eth_payload_tuser)
    );

endmodule

/* logic/axis_skid_buffer.sv */
// registered payload output stage with a temporary register behind a registered ready
`timescale 1ns/1ps

module axis_skid_buffer #(
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic                  in_tvalid,
    input  logic                  in_tlast,
    input  logic [USER_WIDTH-1:0] in_tuser,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic [USER_WIDTH-1:0] out_tuser
);

    logic [DATA_WIDTH-1:0] out_tdata_reg;
    logic                  out_tlast_reg;
    logic [USER_WIDTH-1:0] out_tuser_reg;
    logic                  out_tvalid_reg;
    logic                  out_tvalid_next;

    logic [DATA_WIDTH-1:0] temp_tdata_reg;
    logic                  temp_tlast_reg;
    logic [USER_WIDTH-1:0] temp_tuser_reg;
    logic                  temp_tvalid_reg;
    logic                  temp_tvalid_next;

    logic in_ready_reg;
    logic in_ready_early;
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // ready next cycle unless the temp register could end up full
    assign in_ready_early = out_tready ||
                            (!temp_tvalid_reg && (!out_tvalid_reg || !in_tvalid));

    always_comb begin
        out_tvalid_next   = out_tvalid_reg;
        temp_tvalid_next  = temp_tvalid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (out_tready || !out_tvalid_reg) begin
                // output register free, load directly
                out_tvalid_next = in_tvalid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_tvalid_next = in_tvalid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_tready) begin
            // drain temp into output
            out_tvalid_next   = temp_tvalid_reg;
            temp_tvalid_next  = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid_reg  <= 1'b0;
            temp_tvalid_reg <= 1'b0;
            in_ready_reg    <= 1'b0;
        end else begin
            out_tvalid_reg  <= out_tvalid_next;
            temp_tvalid_reg <= temp_tvalid_next;
            in_ready_reg    <= in_ready_early;
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_tdata_reg <= in_tdata;
            out_tlast_reg <= in_tlast;
            out_tuser_reg <= in_tuser;
        end else if (store_temp_to_out) begin
            out_tdata_reg <= temp_tdata_reg;
            out_tlast_reg <= temp_tlast_reg;
            out_tuser_reg <= temp_tuser_reg;
        end
        if (store_in_to_temp) begin
            temp_tdata_reg <= in_tdata;
            temp_tlast_reg <= in_tlast;
            temp_tuser_reg <= in_tuser;
        end
    end

    assign in_ready   = in_ready_reg;
    assign out_tdata  = out_tdata_reg;
    assign out_tvalid = out_tvalid_reg;
    assign out_tlast  = out_tlast_reg;
    assign out_tuser  = out_tuser_reg;

endmodule

/* logic/arbiter.sv */
// blocking arbiter with fixed priority and round robin modes, released by acknowledge
`timescale 1ns/1ps

module arbiter import eth_mux_pkg::*; #(
    parameter int S_COUNT               = 4,
    parameter int ARB_LSB_HIGH_PRIORITY = 1,
    localparam int CL_S_COUNT           = (S_COUNT > 1) ? $clog2(S_COUNT) : 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  arb_mode_e             arb_mode,
    input  logic [S_COUNT-1:0]    request,
    input  logic [S_COUNT-1:0]    acknowledge,
    output logic [S_COUNT-1:0]    grant,
    output logic                  grant_valid,
    output logic [CL_S_COUNT-1:0] grant_encoded
);

    logic [S_COUNT-1:0]    grant_reg;
    logic [S_COUNT-1:0]    grant_next;
    logic                  grant_valid_reg;
    logic                  grant_valid_next;
    logic [CL_S_COUNT-1:0] grant_encoded_reg;
    logic [CL_S_COUNT-1:0] grant_encoded_next;
    logic [S_COUNT-1:0]    mask_reg;
    logic [S_COUNT-1:0]    mask_next;
    logic [S_COUNT-1:0]    masked_request;
    logic [S_COUNT-1:0]    arb_request;

    // index of the highest priority set bit
    function automatic logic [CL_S_COUNT-1:0] pick(input logic [S_COUNT-1:0] req);
        logic [CL_S_COUNT-1:0] idx;
        idx = '0;
        // later hits override earlier ones, so scan from low to high priority
        for (int i = 0; i < S_COUNT; i++) begin
            if (ARB_LSB_HIGH_PRIORITY != 0) begin
                if (req[S_COUNT-1-i]) begin
                    idx = CL_S_COUNT'(S_COUNT - 1 - i);
                end
            end else if (req[i]) begin
                idx = CL_S_COUNT'(i);
            end
        end
        return idx;
    endfunction

    // requesters strictly after the winner in priority order
    function automatic logic [S_COUNT-1:0] rr_mask(input logic [CL_S_COUNT-1:0] winner);
        logic [S_COUNT-1:0] m;
        for (int i = 0; i < S_COUNT; i++) begin
            m[i] = (ARB_LSB_HIGH_PRIORITY != 0) ? (i > int'(winner)) : (i < int'(winner));
        end
        return m;
    endfunction

    assign masked_request = request & mask_reg;

    // round robin falls back to the full set once the masked set runs dry
    assign arb_request = (arb_mode == ARB_ROUND_ROBIN && |masked_request) ?
                         masked_request : request;

    always_comb begin
        grant_next         = grant_reg;
        grant_valid_next   = grant_valid_reg;
        grant_encoded_next = grant_encoded_reg;
        mask_next          = mask_reg;

        if (grant_valid_reg) begin
            // hold until the owner acknowledges
            if (|(acknowledge & grant_reg)) begin
                grant_next       = '0;
                grant_valid_next = 1'b0;
            end
        end else if (|request) begin
            grant_encoded_next = pick(arb_request);
            grant_next         = S_COUNT'(1) << grant_encoded_next;
            grant_valid_next   = 1'b1;
            mask_next          = rr_mask(grant_encoded_next);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_reg         <= '0;
            grant_valid_reg   <= 1'b0;
            grant_encoded_reg <= '0;
            mask_reg          <= '0;
        end else begin
            grant_reg         <= grant_next;
            grant_valid_reg   <= grant_valid_next;
            grant_encoded_reg <= grant_encoded_next;
            mask_reg          <= mask_next;
        end
    end

    assign grant         = grant_reg;
    assign grant_valid   = grant_valid_reg;
    assign grant_encoded = grant_encoded_reg;

endmodule

/* common/eth_mux_pkg.sv */
// header field types, frame state and arbitration mode enums for the ethernet mux
package eth_mux_pkg;

    // header field widths
    localparam int MAC_ADDR_WIDTH = 48;
    localparam int ETH_TYPE_WIDTH = 16;

    // destination and source address
    typedef logic [MAC_ADDR_WIDTH-1:0] mac_addr_t;

    // ethertype / length field
    typedef logic [ETH_TYPE_WIDTH-1:0] eth_type_t;

    // mux frame tracking
    // active from header handoff until the last payload beat is taken
    typedef enum logic {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_e;

    // arbitration mode, a level input
    // so one build can run both schemes
    typedef enum logic {
        ARB_PRIORITY    = 1'b0,
        ARB_ROUND_ROBIN = 1'b1
    } arb_mode_e;

endpackage
